//--- Bender.yml
package:
  name: mul_wallace

export_include_dirs:
  - verilog

sources:
  # pipelined booth and wallace multiplier
  - include_dirs:
      - verilog
    files:
      - verilog/mul_data_pkg.sv
      - verilog/mul_ctrl_pkg.sv
      - verilog/mul_compressor42.sv
      - verilog/mul_compressor52.sv
      - verilog/mul_booth_stage.sv
      - verilog/mul_csa_stage.sv
      - verilog/mul_final_stage.sv
      - verilog/mul_wallace_top.sv

  # testbench and bound assertions
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/mul_checker.sv
      - bench/tb_mul_wallace.sv

//--- bench/mul_checker.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_checker (
  input logic                   clk,
  input logic                   rst,
  input logic                   valid_i,
  input logic                   ready_i,
  input mul_data_pkg::product_t out_i
);

  // ready low through reset and the first cycle after release
  property p_ready_low_in_reset;
    @(posedge clk) rst |=> !ready_i;
  endproperty

  // strobe taken at edge N, ready set at N+4, seen by the sample at N+5
  property p_fixed_latency;
    @(posedge clk) disable iff (rst) valid_i |-> ##(`MUL_LAT) ready_i;
  endproperty

  // result register only loads together with a ready pulse
  property p_out_holds;
    @(posedge clk) disable iff (rst) !ready_i |-> $stable(out_i);
  endproperty

  a_ready_low_in_reset : assert property (p_ready_low_in_reset)
    else $error("mul_ready_o was high during reset or right after it");

  a_fixed_latency : assert property (p_fixed_latency)
    else $error("mul_ready_o did not follow a mul_valid_i strobe at the fixed latency");

  a_out_holds : assert property (p_out_holds)
    else $error("mul_out_o changed while mul_ready_o was low");

endmodule

bind mul_wallace_top mul_checker u_checker (
  .clk    (clk),
  .rst    (rst),
  .valid_i(mul_valid_i),
  .ready_i(mul_ready_o),
  .out_i  (mul_out_o)
);

//--- bench/tb_mul_wallace.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module tb_mul_wallace;

  import mul_data_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int READY_LAT    = `MUL_LAT - 1;
  localparam int WAIT_LIMIT   = 20;

  logic        clk;
  logic        rst;
  logic        rs1_signed;
  logic        rs2_signed;
  operand_t    rs1_data;
  operand_t    rs2_data;
  logic        mul_valid;
  logic        mul_ready;
  product_t    mul_out;
  logic [31:0] seed;
  int          checks;
  int          errors;

  mul_wallace_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .rs1_signed_i(rs1_signed),
    .rs2_signed_i(rs2_signed),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .mul_valid_i (mul_valid),
    .mul_ready_o (mul_ready),
    .mul_out_o   (mul_out)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic operand_t random_operand();
    return {next_random(), next_random()};
  endfunction

  // widen each operand by its own flag, keep the low 128 bits of the product
  function automatic product_t ref_product(input logic s1, input logic s2,
                                           input operand_t a, input operand_t b);
    product_t a_ext;
    product_t b_ext;
    a_ext = s1 ? {{`MUL_XLEN{a[`MUL_XLEN-1]}}, a} : {{`MUL_XLEN{1'b0}}, a};
    b_ext = s2 ? {{`MUL_XLEN{b[`MUL_XLEN-1]}}, b} : {{`MUL_XLEN{1'b0}}, b};
    return a_ext * b_ext;
  endfunction

  // inputs change and outputs are read 2 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string name, input product_t exp, input product_t got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s expected %0h got %0h", name, exp, got);
    end
  endtask

  // cycles is -1 when ready never came
  task automatic wait_ready(output int cycles);
    cycles = 0;
    while (mul_ready !== 1'b1 && cycles < WAIT_LIMIT) begin
      next_cycle();
      cycles++;
    end
    checks++;
    assert (mul_ready === 1'b1) else begin
      errors++;
      $display("mul_ready_o never went high within %0d cycles", WAIT_LIMIT);
      cycles = -1;
    end
  endtask

  task automatic run_mul(input logic s1, input logic s2, input operand_t a, input operand_t b);
    product_t exp;
    int       cycles;
    exp        = ref_product(s1, s2, a, b);
    rs1_signed = s1;
    rs2_signed = s2;
    rs1_data   = a;
    rs2_data   = b;
    mul_valid  = 1'b1;
    next_cycle();
    mul_valid = 1'b0;
    wait_ready(cycles);
    if (cycles >= 0) begin
      checks++;
      assert (cycles == READY_LAT) else begin
        errors++;
        $display("mul_ready_o came %0d cycles after the strobe, not %0d", cycles, READY_LAT);
      end
      check_value("mul_out_o", exp, mul_out);
      next_cycle();
      // pulse lasts one cycle
      check_value("mul_ready_o", '0, mul_ready);
    end
  endtask

  task automatic test_reset();
    for (int i = 0; i < 3; i++) begin
      check_value("mul_ready_o", '0, mul_ready);
      check_value("mul_out_o", '0, mul_out);
      next_cycle();
    end
  endtask

  task automatic test_unsigned_corners();
    operand_t ones;
    operand_t top;
    ones = '1;
    top  = {1'b1, {(`MUL_XLEN-1){1'b0}}};
    run_mul(1'b0, 1'b0, '0, '0);
    run_mul(1'b0, 1'b0, '0, ones);
    run_mul(1'b0, 1'b0, 64'd1, 64'd1);
    run_mul(1'b0, 1'b0, 64'd1, ones);
    run_mul(1'b0, 1'b0, ones, ones);
    run_mul(1'b0, 1'b0, top, top);
    run_mul(1'b0, 1'b0, top, ones);
    run_mul(1'b0, 1'b0, ones, top);
  endtask

  task automatic test_signed_modes();
    operand_t a_list [8];
    operand_t b_list [8];
    logic [1:0] mode;
    // min*min, min*-1, -1*-1, -1*1, min*max, max*max, small mixed signs
    a_list = '{64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, '1, '1,
               64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, -64'sd5, 64'd123};
    b_list = '{64'h8000_0000_0000_0000, '1, '1, 64'd1,
               64'h7fff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 64'd7, -64'sd456};
    for (int m = 0; m < 4; m++) begin
      mode = m[1:0];
      for (int i = 0; i < 8; i++) begin
        run_mul(mode[1], mode[0], a_list[i], b_list[i]);
      end
    end
  endtask

  task automatic test_back_to_back();
    product_t    exp_q [$];
    logic [31:0] r;
    int          cycles;
    for (int i = 0; i < 5; i++) begin
      r          = next_random();
      rs1_signed = r[4];
      rs2_signed = r[9];
      rs1_data   = random_operand();
      rs2_data   = random_operand();
      exp_q.push_back(ref_product(rs1_signed, rs2_signed, rs1_data, rs2_data));
      mul_valid = 1'b1;
      next_cycle();
    end
    mul_valid = 1'b0;
    wait_ready(cycles);
    if (cycles >= 0) begin
      for (int i = 0; i < 5; i++) begin
        check_value("mul_ready_o", 128'd1, mul_ready);
        check_value("mul_out_o", exp_q.pop_front(), mul_out);
        next_cycle();
      end
      check_value("mul_ready_o", '0, mul_ready);
    end
  endtask

  task automatic test_hold();
    operand_t a;
    operand_t b;
    product_t exp;
    a   = random_operand();
    b   = random_operand();
    exp = ref_product(1'b1, 1'b0, a, b);
    run_mul(1'b1, 1'b0, a, b);
    for (int i = 0; i < 8; i++) begin
      // operands keep moving with no strobe, the result must not follow them
      rs1_data = random_operand();
      rs2_data = random_operand();
      check_value("mul_ready_o", '0, mul_ready);
      check_value("mul_out_o", exp, mul_out);
      next_cycle();
    end
  endtask

  task automatic test_random();
    logic [31:0] r;
    operand_t    a;
    operand_t    b;
    for (int i = 0; i < 200; i++) begin
      r = next_random();
      a = random_operand();
      b = random_operand();
      run_mul(r[3], r[7], a, b);
      // idle gap of zero to three cycles
      repeat (r[13:12]) next_cycle();
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    rs1_signed = 1'b0;
    rs2_signed = 1'b0;
    rs1_data   = '0;
    rs2_data   = '0;
    mul_valid  = 1'b0;
    seed       = 32'ha03e;
    checks     = 0;
    errors     = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    test_reset();
    test_unsigned_corners();
    test_signed_modes();
    test_back_to_back();
    test_hold();
    test_random();

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verilog/mul_booth_stage.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_booth_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rs1_signed_i,
  input  logic                   rs2_signed_i,
  input  mul_data_pkg::operand_t rs1_data_i,
  input  mul_data_pkg::operand_t rs2_data_i,
  input  logic                   valid_i,
  output logic                   valid_o,
  output mul_data_pkg::rows33_t  rows_o
);

  import mul_data_pkg::*;
  import mul_ctrl_pkg::*;

  sign_mode_e               mode;
  logic                     a_sx;
  logic                     b_sx;
  logic [`MUL_XLEN+1:0]     a_ext;
  logic [`MUL_XLEN+2:0]     b_pad;
  product_t                 a_wide;
  booth_op_e                digits [`MUL_PP_ROWS];
  rows33_t                  rows_d;

  // overlapping bit triple to booth digit
  function automatic booth_op_e booth_recode(input logic [2:0] trip);
    unique case (trip)
      3'b001, 3'b010: booth_recode = BOOTH_POS1;
      3'b011:         booth_recode = BOOTH_POS2;
      3'b100:         booth_recode = BOOTH_NEG2;
      3'b101, 3'b110: booth_recode = BOOTH_NEG1;
      default:        booth_recode = BOOTH_ZERO;
    endcase
  endfunction

  assign mode = sign_mode_e'({rs1_signed_i, rs2_signed_i});

  // extension bits per operand
  assign a_sx = (mode == SIGN_SU || mode == SIGN_SS) & rs1_data_i[`MUL_XLEN-1];
  assign b_sx = (mode == SIGN_US || mode == SIGN_SS) & rs2_data_i[`MUL_XLEN-1];

  // 66-bit operands, multiplier padded with the implicit zero below bit 0
  assign a_ext  = {{2{a_sx}}, rs1_data_i};
  assign b_pad  = {{2{b_sx}}, rs2_data_i, 1'b0};
  assign a_wide = {{(`MUL_PLEN-`MUL_XLEN-2){a_ext[`MUL_XLEN+1]}}, a_ext};

  always_comb begin
    for (int j = 0; j < `MUL_PP_ROWS; j++) begin
      digits[j] = booth_recode(b_pad[2*j +: 3]);
    end
  end

  // row j = multiplicand * digit, placed at weight 4^j
  always_comb begin
    product_t pp;
    for (int j = 0; j < `MUL_PP_ROWS; j++) begin
      unique case (digits[j])
        BOOTH_POS1: pp = a_wide;
        BOOTH_POS2: pp = a_wide << 1;
        BOOTH_NEG1: pp = ~a_wide + 1'b1;
        BOOTH_NEG2: pp = ~(a_wide << 1) + 1'b1;
        default:    pp = '0;
      endcase
      rows_d[j] = pp << (2 * j);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // row bank loads every cycle
  always_ff @(posedge clk) begin
    rows_o <= rows_d;
  end

endmodule

//--- verilog/mul_compressor42.sv
`timescale 1ns/1ps

module mul_compressor42 (
  input  logic x0_i,
  input  logic x1_i,
  input  logic x2_i,
  input  logic x3_i,
  input  logic ci_i,
  output logic sum_o,
  output logic carry_o,
  output logic co_o
);

  logic s_fa;

  // first full adder, co_o never sees ci_i
  assign s_fa = x0_i ^ x1_i ^ x2_i;
  assign co_o = (x0_i & x1_i) | (x0_i & x2_i) | (x1_i & x2_i);

  // second full adder absorbs x3 and the horizontal carry
  assign sum_o   = s_fa ^ x3_i ^ ci_i;
  assign carry_o = (s_fa & x3_i) | (s_fa & ci_i) | (x3_i & ci_i);

endmodule

//--- verilog/mul_compressor52.sv
`timescale 1ns/1ps

module mul_compressor52 (
  input  logic x0_i,
  input  logic x1_i,
  input  logic x2_i,
  input  logic x3_i,
  input  logic x4_i,
  input  logic cin0_i,
  input  logic cin1_i,
  output logic sum_o,
  output logic carry_o,
  output logic cout0_o,
  output logic cout1_o
);

  logic s1;
  logic s2;

  // level one, three of the five inputs
  assign s1      = x0_i ^ x1_i ^ x2_i;
  assign cout0_o = (x0_i & x1_i) | (x0_i & x2_i) | (x1_i & x2_i);

  // level two, remaining inputs
  assign s2      = s1 ^ x3_i ^ x4_i;
  assign cout1_o = (s1 & x3_i) | (s1 & x4_i) | (x3_i & x4_i);

  // both horizontal carries only enter here, so nothing ripples
  assign sum_o   = s2 ^ cin0_i ^ cin1_i;
  assign carry_o = (s2 & cin0_i) | (s2 & cin1_i) | (cin0_i & cin1_i);

endmodule

//--- verilog/mul_csa_stage.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_csa_stage #(
  parameter int IN_ROWS = 33
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     valid_i,
  input  mul_data_pkg::product_t [IN_ROWS-1:0]     rows_i,
  output logic                                     valid_o,
  output mul_data_pkg::product_t [IN_ROWS/2-1:0]   rows_o
);

  import mul_data_pkg::*;

  // odd row count puts a 5-2 chain in group 0
  localparam int HAS5  = IN_ROWS % 2;
  localparam int N_GRP = IN_ROWS / `MUL_GRP;

  product_t [IN_ROWS/2-1:0] rows_d;

  for (genvar g = 0; g < N_GRP; g++) begin : g_grp
    localparam int BASE = (g == 0) ? 0 : g * `MUL_GRP + HAS5;

    product_t sum;
    product_t carry;

    if (g == 0 && HAS5 == 1) begin : g_c52
      // horizontal carries, top bit falls off modulo 2^128
      logic [`MUL_PLEN:0] c0;
      logic [`MUL_PLEN:0] c1;

      assign c0[0] = 1'b0;
      assign c1[0] = 1'b0;
      for (genvar b = 0; b < `MUL_PLEN; b++) begin : g_bit
        mul_compressor52 u_c52 (
          .x0_i   (rows_i[0][b]),
          .x1_i   (rows_i[1][b]),
          .x2_i   (rows_i[2][b]),
          .x3_i   (rows_i[3][b]),
          .x4_i   (rows_i[4][b]),
          .cin0_i (c0[b]),
          .cin1_i (c1[b]),
          .sum_o  (sum[b]),
          .carry_o(carry[b]),
          .cout0_o(c0[b+1]),
          .cout1_o(c1[b+1])
        );
      end
    end else begin : g_c42
      logic [`MUL_PLEN:0] co;

      assign co[0] = 1'b0;
      for (genvar b = 0; b < `MUL_PLEN; b++) begin : g_bit
        mul_compressor42 u_c42 (
          .x0_i   (rows_i[BASE][b]),
          .x1_i   (rows_i[BASE+1][b]),
          .x2_i   (rows_i[BASE+2][b]),
          .x3_i   (rows_i[BASE+3][b]),
          .ci_i   (co[b]),
          .sum_o  (sum[b]),
          .carry_o(carry[b]),
          .co_o   (co[b+1])
        );
      end
    end

    // sums first, then carries at double weight
    assign rows_d[g]       = sum;
    assign rows_d[N_GRP+g] = {carry[`MUL_PLEN-2:0], 1'b0};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    rows_o <= rows_d;
  end

endmodule

//--- verilog/mul_ctrl_pkg.sv
package mul_ctrl_pkg;

  // operand signedness, rs1 flag in the upper bit
  typedef enum logic [1:0] {
    SIGN_UU = 2'b00,
    SIGN_US = 2'b01,
    SIGN_SU = 2'b10,
    SIGN_SS = 2'b11
  } sign_mode_e;

  // radix-4 booth digit, one per row
  typedef enum logic [2:0] {
    BOOTH_ZERO = 3'b000,
    BOOTH_POS1 = 3'b001,
    BOOTH_POS2 = 3'b010,
    BOOTH_NEG1 = 3'b101,
    BOOTH_NEG2 = 3'b110
  } booth_op_e;

endpackage

//--- verilog/mul_data_pkg.sv
`include "mul_defines.svh"

package mul_data_pkg;

  // one source operand
  typedef logic [`MUL_XLEN-1:0] operand_t;

  // partial-product row, also the final product
  typedef logic [`MUL_PLEN-1:0] product_t;

  // booth bank straight from recoding
  typedef product_t [`MUL_PP_ROWS-1:0] rows33_t;

  // after first reduction level
  typedef product_t [15:0] rows16_t;

  // after second reduction level
  typedef product_t [7:0] rows8_t;

  // after third level, feeds the final stage
  typedef product_t [3:0] rows4_t;

endpackage

//--- verilog/mul_defines.svh
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// operand width
`define MUL_XLEN 64

// full product width
`define MUL_PLEN 128

// radix-4 booth rows for a 66-bit multiplier
`define MUL_PP_ROWS 33

// rows per 4-2 group in a reduction level
`define MUL_GRP 4

// register stages from strobe to result
`define MUL_LAT 5

`endif

//--- verilog/mul_final_stage.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_final_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  valid_i,
  input  mul_data_pkg::rows4_t  rows_i,
  output logic                  mul_ready_o,
  output mul_data_pkg::product_t mul_out_o
);

  import mul_data_pkg::*;

  logic [`MUL_PLEN:0] co;
  product_t           sum;
  product_t           carry;
  product_t           result;

  // last 4-2 level down to two rows
  assign co[0] = 1'b0;
  for (genvar b = 0; b < `MUL_PLEN; b++) begin : g_bit
    mul_compressor42 u_c42 (
      .x0_i   (rows_i[0][b]),
      .x1_i   (rows_i[1][b]),
      .x2_i   (rows_i[2][b]),
      .x3_i   (rows_i[3][b]),
      .ci_i   (co[b]),
      .sum_o  (sum[b]),
      .carry_o(carry[b]),
      .co_o   (co[b+1])
    );
  end

  // carry-propagate add
  assign result = sum + {carry[`MUL_PLEN-2:0], 1'b0};

  // result holds between ready pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      mul_ready_o <= 1'b0;
      mul_out_o   <= '0;
    end else begin
      mul_ready_o <= valid_i;
      if (valid_i) begin
        mul_out_o <= result;
      end
    end
  end

endmodule

//--- verilog/mul_wallace_top.sv
`timescale 1ns/1ps

module mul_wallace_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rs1_signed_i,
  input  logic                   rs2_signed_i,
  input  mul_data_pkg::operand_t rs1_data_i,
  input  mul_data_pkg::operand_t rs2_data_i,
  input  logic                   mul_valid_i,
  output logic                   mul_ready_o,
  output mul_data_pkg::product_t mul_out_o
);

  import mul_data_pkg::*;

  logic    valid_pp;
  logic    valid_16;
  logic    valid_8;
  logic    valid_4;
  rows33_t rows_pp;
  rows16_t rows_16;
  rows8_t  rows_8;
  rows4_t  rows_4;

  // stage 1, booth rows
  mul_booth_stage u_booth (
    .clk         (clk),
    .rst         (rst),
    .rs1_signed_i(rs1_signed_i),
    .rs2_signed_i(rs2_signed_i),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .valid_i     (mul_valid_i),
    .valid_o     (valid_pp),
    .rows_o      (rows_pp)
  );

  // stages 2 to 4, wallace levels
  mul_csa_stage #(.IN_ROWS(33)) u_csa33 (
    .clk    (clk),
    .rst    (rst),
    .valid_i(valid_pp),
    .rows_i (rows_pp),
    .valid_o(valid_16),
    .rows_o (rows_16)
  );

  mul_csa_stage #(.IN_ROWS(16)) u_csa16 (
    .clk    (clk),
    .rst    (rst),
    .valid_i(valid_16),
    .rows_i (rows_16),
    .valid_o(valid_8),
    .rows_o (rows_8)
  );

  mul_csa_stage #(.IN_ROWS(8)) u_csa8 (
    .clk    (clk),
    .rst    (rst),
    .valid_i(valid_8),
    .rows_i (rows_8),
    .valid_o(valid_4),
    .rows_o (rows_4)
  );

  // stage 5, add and result register
  mul_final_stage u_final (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (valid_4),
    .rows_i     (rows_4),
    .mul_ready_o(mul_ready_o),
    .mul_out_o  (mul_out_o)
  );

endmodule

//--- vlog.f
+incdir+verilog
verilog/mul_data_pkg.sv
verilog/mul_ctrl_pkg.sv
verilog/mul_compressor42.sv
verilog/mul_compressor52.sv
verilog/mul_booth_stage.sv
verilog/mul_csa_stage.sv
verilog/mul_final_stage.sv
verilog/mul_wallace_top.sv
bench/mul_checker.sv
bench/tb_mul_wallace.sv
